/* all.f */
rtl/rc5_pkg.sv
rtl/rc5_tick_gen.sv
rtl/rc5_rx_fsm.sv
rtl/rc5_shift_reg.sv
rtl/rc5_csr.sv
rtl/rc5_top.sv
verif/tb_rc5_top.sv

/* Makefile */
# Verilator build and run for the RC5 receiver testbench

VERILATOR = verilator
VFLAGS    = --binary --timing -j 0 --Mdir $(OBJ_DIR)
TOP       = tb_rc5_top
FILELIST  = all.f

OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
STIM      = verif/rc5_stimulus.txt
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM_BIN) $(STIM)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx 'STATUS: PASS' $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/rc5_stimulus.txt */
# F frame gap irq (frame hex, gap hex cycles, irq 0 or 1) | G width gap (hex cycles)
# R bank idx expected (hex word) | W bank idx value (hex word)
# state after reset
R 3 1 00000000
R 3 2 00000001
R 0 2 00000000
# single frame, then clear valid
F 1a5b 0c8 1
R 3 0 00001a5b
R 3 1 00000001
W 3 1 00000001
R 3 1 00000000
# short glitches rejected at the start check
G 0c 0c8
G 06 096
R 3 0 00001a5b
R 3 1 00000000
# two frames without clearing valid
F 0c3e 0c8 1
F 1555 0c8 1
R 3 0 00001555
R 3 1 00000003
W 3 1 00000003
R 3 1 00000000
# receiver disabled, then enabled again
W 3 2 00000000
R 3 2 00000000
F 0f0f 0c8 0
R 3 0 00001555
R 3 1 00000000
W 3 2 00000001
R 3 2 00000001
F 1ff0 0c8 1
R 3 0 00001ff0
R 3 1 00000001
W 3 1 00000001
# other banks and the unused index
R 0 0 00000000
R 5 1 00000000
R f 2 00000000
R 3 3 00000000
W 2 2 00000000
R 3 2 00000001
# edge values, the second one overruns
F 0001 0c8 1
F 1000 0c8 1
R 3 0 00001000
W 2 1 00000003
R 3 1 00000003
W 3 1 00000003
R 3 1 00000000

/* verif/tb_rc5_top.sv */
// testbench for the RC5 receiver top level
// clock and reset, stimulus file reader, IR line driver
// CSR read and write tasks, typed compare tasks, irq counter
// cycle-count timeout and closing report

`timescale 1ns/1ps

module tb_rc5_top import rc5_pkg::*; ();

	localparam logic [3:0] bank         = 4'h3;
	localparam int         clk_freq     = 36480;
	localparam int         bit_rate     = 570;
	localparam int         bit_cycles   = clk_freq / bit_rate; // 64 clocks per bit
	localparam int         irq_window   = 2 * bit_cycles;      // irq due half a bit after the end
	localparam int         frame_cycles = (rc5_frame_bits + 2) * bit_cycles; // whole frame plus margin

	logic        sys_clk;
	logic        sys_rst;
	logic [13:0] csr_a;
	logic        csr_we;
	csr_word_t   csr_di;
	csr_word_t   csr_do;
	logic        rx_irq;
	logic        rx;

	int value_errs;   // wrong values
	int other_errs;   // missing irq or bad stimulus line
	int irq_count;    // rx_irq pulses seen
	int exp_irq;      // pulses the stimulus asked for
	int cycle_cnt;
	int limit_cycles;
	int seed;

	rc5_top #(
		.csr_addr (bank),
		.clk_freq (clk_freq),
		.bit_rate (bit_rate)
	) i_dut (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.csr_a   (csr_a),
		.csr_we  (csr_we),
		.csr_di  (csr_di),
		.csr_do  (csr_do),
		.rx_irq  (rx_irq),
		.rx      (rx)
	);

	initial sys_clk = 1'b0;
	always #4 sys_clk = ~sys_clk; // 8 ns period

	// one count per pulse
	always @(posedge sys_clk) begin
		if (sys_rst)
			irq_count <= 0;
		else if (rx_irq)
			irq_count <= irq_count + 1;
	end

	//----------------------------------------------------------------------
	// reporting and compares
	//----------------------------------------------------------------------
	task automatic report_counts(input int v_errs, input int o_errs);
		$display("errors: %0d value mismatches, %0d other failures", v_errs, o_errs);
	endtask

	// limit set once the stimulus lines are counted
	always @(posedge sys_clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (limit_cycles > 0 && cycle_cnt > limit_cycles) begin
			$display("timeout: stimulus not finished after %0d cycles", limit_cycles);
			report_counts(value_errs, other_errs + 1);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	task automatic check_frame(input string name, input rc5_frame_t exp, input rc5_frame_t act);
		if (act !== exp) begin
			$display("ERR %s: expected %h, actual %h", name, exp, act);
			value_errs++;
		end
	endtask

	task automatic check_status(input string name, input rc5_status_t exp,
			input rc5_status_t act);
		if (act !== exp) begin
			$display("ERR %s: expected %h, actual %h", name, exp, act);
			value_errs++;
		end
	endtask

	task automatic check_word(input string name, input csr_word_t exp, input csr_word_t act);
		if (act !== exp) begin
			$display("ERR %s: expected %h, actual %h", name, exp, act);
			value_errs++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("ERR %s: expected %0d irq, actual %0d", name, exp, act);
			value_errs++;
		end
	endtask

	//----------------------------------------------------------------------
	// CSR bus driven on the falling edge
	//----------------------------------------------------------------------
	task automatic csr_read(input logic [3:0] bank_sel, input logic [1:0] idx,
			output csr_word_t data);
		@(negedge sys_clk);
		csr_a  = {bank_sel, 8'd0, idx};
		csr_we = 1'b0;
		@(negedge sys_clk); // read mux loaded on the edge between
		data = csr_do;
	endtask

	task automatic csr_write(input logic [3:0] bank_sel, input logic [1:0] idx,
			input csr_word_t value);
		@(negedge sys_clk);
		csr_a  = {bank_sel, 8'd0, idx};
		csr_di = value;
		csr_we = 1'b1;
		@(negedge sys_clk);
		csr_we = 1'b0;
	endtask

	task automatic check_read(input int line_no, input logic [3:0] bank_sel,
			input logic [1:0] idx, input csr_word_t exp);
		csr_word_t rd;
		string     name;
		name = $sformatf("line %0d read %h:%0d", line_no, bank_sel, idx);
		csr_read(bank_sel, idx, rd);
		if (bank_sel != bank) begin
			check_word(name, exp, rd); // foreign bank reads zero
		end else begin
			case (rc5_reg_e'(idx))
				reg_data: begin
					check_frame(name, exp[12:0], rd[12:0]);
					// zero extension above the frame
					check_word(name, {exp[31:13], 13'd0}, {rd[31:13], 13'd0});
				end
				reg_status: begin
					check_status(name, rc5_status_t'(exp[1:0]),
						rc5_status_t'(rd[1:0]));
					check_word(name, {exp[31:2], 2'd0}, {rd[31:2], 2'd0});
				end
				default: check_word(name, exp, rd); // ctrl and unused index
			endcase
		end
	endtask

	//----------------------------------------------------------------------
	// IR line driver
	//----------------------------------------------------------------------
	task automatic drive_bit(input logic b);
		rx = b;
		repeat (bit_cycles) @(negedge sys_clk);
	endtask

	task automatic idle_gap(input int cycles);
		int jitter;
		jitter = $unsigned($random(seed)) % 16; // 0..15 extra cycles
		repeat (cycles + jitter) @(negedge sys_clk);
	endtask

	task automatic run_frame(input int line_no, input rc5_frame_t value, input int gap,
			input bit irq_exp);
		string name;
		int    waited;
		name = $sformatf("line %0d frame %h", line_no, value);
		drive_bit(1'b1); // start bit
		for (int i = rc5_frame_bits - 1; i >= 0; i--)
			drive_bit(value[i]); // msb first
		rx = 1'b0;
		if (irq_exp) begin
			exp_irq = exp_irq + 1;
			waited  = 0;
			while (irq_count < exp_irq && waited < irq_window) begin
				@(negedge sys_clk);
				waited++;
			end
			if (irq_count < exp_irq) begin
				$display("%s: no rx_irq within %0d cycles of the frame end", name, irq_window);
				other_errs++;
			end
		end else begin
			repeat (irq_window) @(negedge sys_clk); // room for a stray irq
		end
		idle_gap(gap);
		check_count(name, exp_irq, irq_count); // exactly one or none
	endtask

	task automatic run_glitch(input int line_no, input int width, input int gap);
		string name;
		name = $sformatf("line %0d glitch %0d", line_no, width);
		rx = 1'b1;
		repeat (width) @(negedge sys_clk);
		rx = 1'b0;
		// an accepted glitch would run a full frame before its irq
		repeat (frame_cycles) @(negedge sys_clk);
		idle_gap(gap);
		check_count(name, exp_irq, irq_count);
	endtask

	task automatic bad_line(input int line_no);
		$display("line %0d: stimulus fields missing or malformed", line_no);
		other_errs++;
	endtask

	//----------------------------------------------------------------------
	// main sequence
	//----------------------------------------------------------------------
	initial begin
		int          fd;
		int          n_lines;
		int          code;
		int          line_no;
		bit          done_reading;
		logic [7:0]  op;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		string       text;

		value_errs   = 0;
		other_errs   = 0;
		exp_irq      = 0;
		cycle_cnt    = 0;
		limit_cycles = 0;
		n_lines      = 0;
		seed         = 32'he7a7;
		sys_rst      = 1'b1;
		rx           = 1'b0; // line idles low
		csr_a        = '0;
		csr_we       = 1'b0;
		csr_di       = '0;

		// size the timeout from the stimulus length
		fd = $fopen("verif/rc5_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open verif/rc5_stimulus.txt");
			other_errs++;
		end else begin
			while ($fgets(text, fd) != 0)
				n_lines++;
			$fclose(fd);
		end
		limit_cycles = n_lines * 20 * bit_cycles;

		repeat (8) @(negedge sys_clk);
		sys_rst = 1'b0;
		repeat (2) @(negedge sys_clk);
		check_count("after reset", 0, irq_count);

		if (n_lines > 0) begin
			fd = $fopen("verif/rc5_stimulus.txt", "r");
			done_reading = 1'b0;
			line_no = 0;
			while (!done_reading) begin
				code = $fscanf(fd, " %c", op);
				if (code != 1) begin
					done_reading = 1'b1; // end of file
				end else begin
					line_no++;
					case (op)
						"#": code = $fgets(text, fd); // comment line
						"F": begin
							code = $fscanf(fd, "%h %h %h", f1, f2, f3);
							if (code != 3)
								bad_line(line_no);
							else
								run_frame(line_no, f1[12:0], f2, f3[0]);
						end
						"G": begin
							code = $fscanf(fd, "%h %h", f1, f2);
							if (code != 2)
								bad_line(line_no);
							else
								run_glitch(line_no, f1, f2);
						end
						"R": begin
							code = $fscanf(fd, "%h %h %h", f1, f2, f3);
							if (code != 3)
								bad_line(line_no);
							else
								check_read(line_no, f1[3:0], f2[1:0], f3);
						end
						"W": begin
							code = $fscanf(fd, "%h %h %h", f1, f2, f3);
							if (code != 3)
								bad_line(line_no);
							else
								csr_write(f1[3:0], f2[1:0], f3);
						end
						default: begin
							$display("line %0d: unknown stimulus operation '%c'", line_no, op);
							other_errs++;
							done_reading = 1'b1;
						end
					endcase
				end
			end
			$fclose(fd);
		end

		check_count("end of run", exp_irq, irq_count);
		report_counts(value_errs, other_errs);
		if (value_errs + other_errs == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* rtl/rc5_top.sv */
// RC5 infrared receiver top level
// tick generator, receive FSM, data path and CSR block

`timescale 1ns/1ps

module rc5_top import rc5_pkg::*; #(
	parameter logic [3:0] csr_addr = 4'h0,
	parameter int         clk_freq = 100000000,
	parameter int         bit_rate = rc5_default_bit_rate
) (
	input  logic        sys_clk,
	input  logic        sys_rst,

	input  logic [13:0] csr_a,
	input  logic        csr_we,
	input  csr_word_t   csr_di,
	output csr_word_t   csr_do,

	output logic        rx_irq,

	input  logic        rx    // IR line, idle low
);

	logic       tick;       // 16x bit rate
	logic       rx_sync;
	logic       shift_en;
	logic       capture_en;
	logic       frame_done;
	logic       rx_enable;
	rc5_frame_t frame;      // last complete frame

	//----------------------------------------------------------------------
	// receive side
	//----------------------------------------------------------------------
	rc5_tick_gen #(
		.clk_freq (clk_freq),
		.bit_rate (bit_rate)
	) i_tick_gen (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.tick    (tick)
	);

	rc5_rx_fsm i_rx_fsm (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.tick       (tick),
		.rx_sync    (rx_sync),
		.rx_enable  (rx_enable),
		.shift_en   (shift_en),
		.capture_en (capture_en),
		.frame_done (frame_done)
	);

	rc5_shift_reg i_shift_reg (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.rx         (rx),
		.shift_en   (shift_en),
		.capture_en (capture_en),
		.rx_sync    (rx_sync),
		.frame      (frame)
	);

	// host side
	rc5_csr #(
		.csr_addr (csr_addr)
	) i_csr (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.csr_a      (csr_a),
		.csr_we     (csr_we),
		.csr_di     (csr_di),
		.csr_do     (csr_do),
		.frame      (frame),
		.frame_done (frame_done),
		.rx_enable  (rx_enable),
		.rx_irq     (rx_irq)
	);

endmodule

/* rtl/rc5_csr.sv */
// CSR block for the RC5 receiver
// bank decode, registered read mux, valid and overrun flags
// receiver enable bit, irq pulse on each frame

`timescale 1ns/1ps

module rc5_csr import rc5_pkg::*; #(
	parameter logic [3:0] csr_addr = 4'h0
) (
	input  logic        sys_clk,
	input  logic        sys_rst,
	input  logic [13:0] csr_a,
	input  logic        csr_we,
	input  csr_word_t   csr_di,
	output csr_word_t   csr_do,
	input  rc5_frame_t  frame,
	input  logic        frame_done,
	output logic        rx_enable,
	output logic        rx_irq
);

	logic        csr_sel; // bank match
	logic        wr_en;
	rc5_reg_e    reg_idx;
	rc5_status_t status;

	assign csr_sel = (csr_a[13:10] == csr_addr);
	assign wr_en   = csr_sel && csr_we;
	assign reg_idx = rc5_reg_e'(csr_a[1:0]);

	//----------------------------------------------------------------------
	// flags, enable and irq
	//----------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			status    <= '0;
			rx_enable <= 1'b1; // listen by default
			rx_irq    <= 1'b0;
		end else begin
			rx_irq <= frame_done; // one cycle after the FSM strobe

			if (wr_en && reg_idx == reg_ctrl)
				rx_enable <= csr_di[0];

			// write 1 to clear
			if (wr_en && reg_idx == reg_status) begin
				if (csr_di[0])
					status.valid <= 1'b0;
				if (csr_di[1])
					status.overrun <= 1'b0;
			end

			// new frame beats a clear in the same cycle
			if (frame_done) begin
				status.valid <= 1'b1;
				if (status.valid)
					status.overrun <= 1'b1; // previous frame never acked
			end
		end
	end

	// read data, one cycle after csr_a
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do <= '0;
		end else begin
			csr_do <= '0;
			if (csr_sel) begin
				case (reg_idx)
					reg_data:   csr_do <= csr_word_t'(frame);
					reg_status: csr_do <= csr_word_t'(status);
					reg_ctrl:   csr_do <= csr_word_t'(rx_enable);
					default:    csr_do <= '0; // index 3 unused
				endcase
			end
		end
	end

endmodule

/* rtl/rc5_shift_reg.sv */
// RC5 receive data path
// two-flop line synchronizer, 13-bit shift register, held frame

`timescale 1ns/1ps

module rc5_shift_reg import rc5_pkg::*; (
	input  logic       sys_clk,
	input  logic       sys_rst,
	input  logic       rx,          // raw IR line, asynchronous
	input  logic       shift_en,
	input  logic       capture_en,
	output logic       rx_sync,
	output rc5_frame_t frame
);

	logic       rx_meta; // first stage, may go metastable
	rc5_frame_t shreg;

	//----------------------------------------------------------------------
	// synchronizer, line idles low
	//----------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			rx_meta <= 1'b0;
			rx_sync <= 1'b0;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta; // two cycles behind rx
		end
	end

	// new bits enter at the low end, first bit ends up as MSB
	always_ff @(posedge sys_clk) begin
		if (shift_en)
			shreg <= {shreg[rc5_frame_bits-2:0], rx_sync};
	end

	// held frame for the host
	always_ff @(posedge sys_clk) begin
		if (capture_en)
			frame <= shreg;
	end

endmodule

/* rtl/rc5_rx_fsm.sv */
// RC5 frame receiver FSM
// start level detect, mid-bit start check, 13 data samples
// tick-phase and bit counters, shift and capture strobes

`timescale 1ns/1ps

module rc5_rx_fsm import rc5_pkg::*; (
	input  logic sys_clk,
	input  logic sys_rst,
	input  logic tick,       // sixteen per bit
	input  logic rx_sync,    // synchronized line level
	input  logic rx_enable,  // gate for new frames only
	output logic shift_en,
	output logic capture_en,
	output logic frame_done
);

	// last data sample index, bit counter starts at 0
	localparam logic [3:0] last_bit = 4'(rc5_frame_bits - 1);
	// phase loaded on start detect, wraps to 0 five ticks later
	localparam logic [3:0] start_phase = 4'd11;

	rc5_state_e state;
	logic [3:0] phase;   // position within the bit, in ticks
	logic [3:0] bit_cnt; // data bits shifted so far
	logic       sample;  // tick on which a sample is due

	// sample when the phase wraps 15 -> 0
	assign sample = tick && (phase == 4'd15) && (state != idle);

	//----------------------------------------------------------------------
	// state, phase and bit counter
	//----------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state   <= idle;
			phase   <= 4'd0;
			bit_cnt <= 4'd0;
		end else begin
			if (tick && state != idle)
				phase <= phase + 4'd1; // free running while busy

			case (state)
				idle: begin
					// high line on a tick starts a frame
					if (tick && rx_sync && rx_enable) begin
						state   <= start_check;
						phase   <= start_phase;
						bit_cnt <= 4'd0;
					end
				end
				start_check: begin
					if (sample) begin
						if (!rx_sync)
							state <= idle; // glitch, drop it
						else
							state <= data;
					end
				end
				data: begin
					if (sample) begin
						bit_cnt <= bit_cnt + 4'd1;
						if (bit_cnt == last_bit)
							state <= done; // thirteenth bit in
					end
				end
				done: begin
					if (sample)
						state <= idle; // capture happens here
				end
				default: state <= idle;
			endcase
		end
	end

	//----------------------------------------------------------------------
	// one-cycle strobes to the data path and CSR block
	//----------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			shift_en   <= 1'b0;
			capture_en <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			shift_en   <= sample && (state == data);
			capture_en <= sample && (state == done);
			frame_done <= sample && (state == done); // same cycle as capture
		end
	end

endmodule

/* rtl/rc5_tick_gen.sv */
// oversampling time base for the RC5 receiver
// one-cycle tick, sixteen per bit period

`timescale 1ns/1ps

module rc5_tick_gen import rc5_pkg::*; #(
	parameter int clk_freq = 100000000,
	parameter int bit_rate = rc5_default_bit_rate
) (
	input  logic sys_clk,
	input  logic sys_rst,
	output logic tick
);

	// clocks per oversample tick
	localparam int divisor = clk_freq / (16 * bit_rate);
	localparam logic [15:0] reload = 16'(divisor - 1);

	logic [15:0] cnt;
	logic        cnt_zero;

	assign cnt_zero = (cnt == 16'd0);

	// down-counter, reloads on zero
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			cnt <= reload;
		end else if (cnt_zero) begin
			cnt <= reload;
		end else begin
			cnt <= cnt - 16'd1;
		end
	end

	// registered so the tick is glitch free at the FSM
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			tick <= 1'b0;
		end else begin
			tick <= cnt_zero; // first one lands divisor cycles after reset
		end
	end

endmodule

/* rtl/rc5_pkg.sv */
// shared types and constants for the RC5 infrared receiver
// frame and CSR word types, status flags, state and register enums
// default IR bit rate

package rc5_pkg;

	//----------------------------------------------------------------------
	// constants
	//----------------------------------------------------------------------
	localparam int rc5_frame_bits       = 13;  // bits shifted after the start bit
	localparam int rc5_default_bit_rate = 570; // bits per second on the line

	//----------------------------------------------------------------------
	// data types
	//----------------------------------------------------------------------
	typedef logic [rc5_frame_bits-1:0] rc5_frame_t; // first bit received is MSB
	typedef logic [31:0] csr_word_t;

	// status register, zero-extended on the bus
	typedef struct packed {
		logic overrun; // bit 1, frame lost
		logic valid;   // bit 0, held frame not yet acknowledged
	} rc5_status_t;

	// receiver FSM
	typedef enum logic [1:0] {
		idle        = 2'd0, // waiting for a rising line
		start_check = 2'd1, // confirm start level at sample 0
		data        = 2'd2, // samples 1 to 13
		done        = 2'd3  // final sample, capture frame
	} rc5_state_e;

	// register index from csr_a[1:0]
	typedef enum logic [1:0] {
		reg_data   = 2'd0,
		reg_status = 2'd1,
		reg_ctrl   = 2'd2
	} rc5_reg_e;

endpackage
